/* Makefile */
.PHONY: run clean

run: obj_dir/Vtb_regq
	@out="$$(./obj_dir/Vtb_regq)"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

obj_dir/Vtb_regq: project.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --assert -j 0 --top-module tb_regq -f project.f -Mdir obj_dir -o Vtb_regq

clean:
	rm -rf obj_dir

/* bench/tb_regq.sv */
`timescale 1ns/10ps

module tb_regq;

    import regq_pkg::*;

    localparam int HALF_PERIOD   = 50;
    localparam int SAMPLE_DELAY  = 10;
    localparam int READY_TIMEOUT = 40;
    localparam int RESP_TIMEOUT  = 60;
    localparam int HOLD_TIMEOUT  = 20;

    logic        i_clk;
    logic        i_nrst;
    logic        i_awvalid;
    logic        o_awready;
    logic [31:0] i_awaddr;
    logic        i_wvalid;
    logic        o_wready;
    logic [31:0] i_wdata;
    logic [3:0]  i_wstrb;
    logic        o_bvalid;
    logic        i_bready;
    logic [1:0]  o_bresp;
    logic        i_arvalid;
    logic        o_arready;
    logic [31:0] i_araddr;
    logic        o_rvalid;
    logic        i_rready;
    logic [31:0] o_rdata;
    logic [1:0]  o_rresp;

    // Reference copy of the register bank where entry 15 holds the ID word
    logic [31:0] shadow [REG_COUNT];
    logic [31:0] rng_state;

    regq_top uut (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #HALF_PERIOD i_clk = ~i_clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Strobed byte lanes take the new data and the others keep the old value
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [1:0] expected_resp(input logic [7:0] widx, input bit is_write);
        if (widx > 8'd15 || (is_write && widx == 8'd15)) begin
            return RESP_SLVERR;
        end
        return RESP_OKAY;
    endfunction

    function automatic logic [31:0] expected_rdata(input logic [7:0] widx);
        if (widx > 8'd15) begin
            return '0;
        end
        return shadow[widx[3:0]];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            fail_now($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Presents one request and waits for its address handshake or the limit
    task automatic offer_request(input bit is_read, input logic [31:0] addr,
                                 input logic [31:0] data, input logic [3:0] strb,
                                 input int limit, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        if (is_read) begin
            i_arvalid = 1'b1;
            i_araddr  = addr;
        end else begin
            i_awvalid = 1'b1;
            i_wvalid  = 1'b1;
            i_awaddr  = addr;
            i_wdata   = data;
            i_wstrb   = strb;
        end
        while (!ok && n < limit) begin
            #SAMPLE_DELAY;
            assert (o_awready == o_wready) else fail_now("AW and W ready differ");
            ok = is_read ? o_arready : o_awready;
            @(negedge i_clk);
            n++;
        end
        i_arvalid = 1'b0;
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
    endtask

    // Waits for a B or R response and can stall ready at random
    task automatic collect_resp(input bit is_read, input bit stall, output logic [1:0] resp,
                                output logic [31:0] data, output int cycles);
        logic [31:0] r;
        bit          done;
        done   = 1'b0;
        cycles = 0;
        while (!done) begin
            r = next_random();
            if (is_read) begin
                i_rready = stall ? r[0] : 1'b1;
            end else begin
                i_bready = stall ? r[0] : 1'b1;
            end
            #SAMPLE_DELAY;
            assert (!(is_read ? o_bvalid : o_rvalid)) else begin
                fail_now("a response appeared on the wrong channel");
            end
            if (is_read ? (o_rvalid && i_rready) : (o_bvalid && i_bready)) begin
                resp = is_read ? o_rresp : o_bresp;
                data = o_rdata;
                done = 1'b1;
            end
            @(negedge i_clk);
            cycles++;
            if (!done && cycles >= RESP_TIMEOUT) begin
                fail_now("no response arrived before the timeout");
            end
        end
        i_bready = 1'b1;
        i_rready = 1'b1;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input bit stall,
                             output logic [1:0] resp, output int cycles);
        bit          ok;
        logic [31:0] unused_data;
        offer_request(1'b0, addr, data, strb, READY_TIMEOUT, ok);
        if (!ok) begin
            fail_now("the write request was never accepted");
        end
        collect_resp(1'b0, stall, resp, unused_data, cycles);
    endtask

    task automatic axi_read(input logic [31:0] addr, input bit stall,
                            output logic [1:0] resp, output logic [31:0] data);
        bit ok;
        int cycles;
        offer_request(1'b1, addr, '0, '0, READY_TIMEOUT, ok);
        if (!ok) begin
            fail_now("the read request was never accepted");
        end
        collect_resp(1'b1, stall, resp, data, cycles);
    endtask

    task automatic write_check(input string name, input logic [31:0] addr,
                               input logic [31:0] data, input logic [3:0] strb,
                               input bit stall, output int cycles);
        logic [1:0] resp;
        axi_write(addr, data, strb, stall, resp, cycles);
        check_value(name, 32'(expected_resp(addr[9:2], 1'b1)), 32'(resp));
        if (addr[9:2] < 8'd15) begin
            shadow[addr[5:2]] = merge_bytes(shadow[addr[5:2]], data, strb);
        end
    endtask

    task automatic read_check(input string name, input logic [31:0] addr, input bit stall);
        logic [1:0]  resp;
        logic [31:0] data;
        axi_read(addr, stall, resp, data);
        check_value({name, "_resp"}, 32'(expected_resp(addr[9:2], 1'b0)), 32'(resp));
        check_value({name, "_data"}, expected_rdata(addr[9:2]), data);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] r;
        logic [31:0] addr;
        logic [7:0]  widx;
        logic [3:0]  idx;
        logic [1:0]  resp;
        int          cycles;
        int          accepted;
        bit          ok;

        i_nrst    = 1'b0;
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_bready  = 1'b1;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_rready  = 1'b1;
        rng_state = 32'h32fa;
        for (int i = 0; i < REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        shadow[REG_COUNT - 1] = ID_WORD;

        repeat (4) @(negedge i_clk);
        i_nrst = 1'b1;
        #SAMPLE_DELAY;
        assert (!o_bvalid && !o_rvalid && !o_awready && !o_wready && !o_arready) else begin
            fail_now("handshake outputs are not low after reset");
        end
        @(negedge i_clk);

        for (int i = 0; i < 15; i++) begin
            read_check("reset_read", 32'(i * 4), 1'b0);
        end
        read_check("id_read", 32'h3c, 1'b0);

        // Each full-word write should see its B handshake one cycle after the AW edge
        for (int i = 0; i < 15; i += 7) begin
            write_check("readback_write", 32'(i * 4), next_random(), 4'hf, 1'b0, cycles);
            check_value("readback_latency", 32'd1, 32'(cycles));
        end
        for (int i = 0; i < 15; i += 7) begin
            read_check("readback_read", 32'(i * 4), 1'b0);
        end

        write_check("strobe_init", 32'h0c, 32'h1122_3344, 4'hf, 1'b0, cycles);
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            write_check("strobe_write", 32'h0c, next_random(), r[3:0], 1'b0, cycles);
            read_check("strobe_read", 32'h0c, 1'b0);
        end

        write_check("id_write", 32'h3c, 32'hffff_ffff, 4'hf, 1'b0, cycles);
        read_check("id_after_write", 32'h3c, 1'b0);
        read_check("range_read", 32'h40, 1'b0);
        read_check("range_read_high", 32'h3fc, 1'b0);
        write_check("range_write", 32'h44, 32'hdead_beef, 4'hf, 1'b0, cycles);
        read_check("range_alias", 32'h04, 1'b0);

        // With B stalled the pipeline fills until AW stops being accepted
        i_bready = 1'b0;
        accepted = 0;
        ok       = 1'b1;
        while (ok) begin
            data = next_random();
            idx  = 4'(accepted % 14);
            offer_request(1'b0, {26'd0, idx, 2'b00}, data, 4'hf, HOLD_TIMEOUT, ok);
            if (ok) begin
                shadow[idx] = data;
                accepted++;
            end
            if (accepted > 32) begin
                fail_now("writes kept being accepted while B was stalled");
            end
        end
        assert (accepted >= 1) else fail_now("no write was accepted before the stall");
        for (int i = 0; i < accepted; i++) begin
            collect_resp(1'b0, 1'b0, resp, data, cycles);
            check_value("backpressure_bresp", 32'(RESP_OKAY), 32'(resp));
        end
        repeat (4) begin
            #SAMPLE_DELAY;
            assert (!o_bvalid && !o_rvalid) else begin
                fail_now("an extra response followed the held writes");
            end
            @(negedge i_clk);
        end
        for (int i = 0; i < 14; i++) begin
            read_check("backpressure_read", 32'(i * 4), 1'b0);
        end

        for (int n = 0; n < 200; n++) begin
            r    = next_random();
            widx = r[15:8] % 8'd18;
            addr = {22'd0, widx, r[1:0]};
            if (r[24]) begin
                write_check("random_write", addr, next_random(), r[19:16], 1'b1, cycles);
            end else begin
                read_check("random_read", addr, 1'b1);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

/* logic/axil_req_capture.sv */
`timescale 1ns/10ps

module axil_req_capture (
    input  logic             i_clk,
    input  logic             i_nrst,
    // Write address channel
    input  logic             i_awvalid,
    output logic             o_awready,
    input  logic [31:0]      i_awaddr,
    // Write data channel
    input  logic             i_wvalid,
    output logic             o_wready,
    input  logic [31:0]      i_wdata,
    input  logic [3:0]       i_wstrb,
    // Read address channel
    input  logic             i_arvalid,
    output logic             o_arready,
    input  logic [31:0]      i_araddr,
    // Request queue push side
    input  logic             i_q_full,
    output logic             o_q_we,
    output regq_pkg::req_t   o_q_req
);

    logic wr_pend;
    logic rd_turn;
    logic wr_grant;
    logic rd_grant;
    logic last_wr_r;

    // A write needs both its address and its data before it can go
    assign wr_pend = i_awvalid & i_wvalid;

    // A waiting read gets one turn after each accepted write
    assign rd_turn = i_arvalid & last_wr_r;

    assign wr_grant = wr_pend & ~i_q_full & ~rd_turn;
    assign rd_grant = i_arvalid & ~i_q_full & (~wr_pend | rd_turn);

    assign o_awready = wr_grant;
    assign o_wready  = wr_grant;
    assign o_arready = rd_grant;
    assign o_q_we    = wr_grant | rd_grant;

    always_comb begin
        if (rd_grant) begin
            o_q_req.is_write = 1'b0;
            o_q_req.waddr    = i_araddr[9:2];
            o_q_req.wdata    = '0;
            o_q_req.wstrb    = '0;
        end else begin
            // Low two address bits are dropped, accesses are word aligned
            o_q_req.is_write = 1'b1;
            o_q_req.waddr    = i_awaddr[9:2];
            o_q_req.wdata    = i_wdata;
            o_q_req.wstrb    = i_wstrb;
        end
    end

    // Remembers whether the most recent grant went to a write
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            last_wr_r <= 1'b0;
        end else if (wr_grant) begin
            last_wr_r <= 1'b1;
        end else if (rd_grant) begin
            last_wr_r <= 1'b0;
        end
    end

endmodule

/* logic/axil_resp_issue.sv */
`timescale 1ns/10ps

module axil_resp_issue (
    input  logic           i_clk,
    input  logic           i_nrst,
    // Response queue pop side
    input  logic           i_q_nempty,
    input  regq_pkg::rsp_t i_q_rsp,
    output logic           o_q_re,
    // Write response channel
    output logic           o_bvalid,
    input  logic           i_bready,
    output logic [1:0]     o_bresp,
    // Read data channel
    output logic           o_rvalid,
    input  logic           i_rready,
    output logic [31:0]    o_rdata,
    output logic [1:0]     o_rresp
);

    import regq_pkg::*;

    rsp_t rsp_r;
    logic valid_r;
    logic accept;

    // The held response leaves on whichever channel it belongs to
    assign accept = valid_r & (rsp_r.is_read ? i_rready : i_bready);
    assign o_q_re = i_q_nempty & (~valid_r | accept);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            valid_r <= 1'b0;
        end else if (o_q_re) begin
            valid_r <= 1'b1;
        end else if (accept) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_q_re) begin
            rsp_r <= i_q_rsp;
        end
    end

    assign o_bvalid = valid_r & ~rsp_r.is_read;
    assign o_rvalid = valid_r & rsp_r.is_read;
    assign o_bresp  = rsp_r.resp;
    assign o_rresp  = rsp_r.resp;
    assign o_rdata  = rsp_r.rdata;

endmodule

/* logic/reg_exec.sv */
`timescale 1ns/10ps

module reg_exec (
    input  logic           i_clk,
    input  logic           i_nrst,
    // Request queue pop side
    input  logic           i_req_nempty,
    input  regq_pkg::req_t i_req,
    output logic           o_req_re,
    // Response queue push side
    input  logic           i_rsp_full,
    output logic           o_rsp_we,
    output regq_pkg::rsp_t o_rsp
);

    import regq_pkg::*;

    // Writable registers 0 to 14, the last index is the fixed ID word
    logic [31:0] regs_r [REG_COUNT - 1];

    logic [REG_IDX_W-1:0] idx;
    logic                 in_range;
    logic                 is_id;
    logic                 err;
    logic                 do_write;
    logic [31:0]          rd_word;

    // One request per cycle, as long as its response has room
    assign o_req_re = i_req_nempty & ~i_rsp_full;
    assign o_rsp_we = o_req_re;

    assign idx      = i_req.waddr[REG_IDX_W-1:0];
    assign in_range = ~|i_req.waddr[7:REG_IDX_W];
    assign is_id    = (idx == REG_IDX_W'(REG_COUNT - 1));
    assign err      = ~in_range | (i_req.is_write & is_id);
    assign do_write = o_req_re & i_req.is_write & ~err;

    always_comb begin
        if (!in_range) begin
            rd_word = '0;
        end else if (is_id) begin
            rd_word = ID_WORD;
        end else begin
            rd_word = regs_r[idx];
        end
    end

    always_comb begin
        o_rsp.is_read = ~i_req.is_write;
        o_rsp.rdata   = i_req.is_write ? '0 : rd_word;
        o_rsp.resp    = err ? RESP_SLVERR : RESP_OKAY;
    end

    // Byte lanes are merged under the write strobe
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < REG_COUNT - 1; i++) begin
                regs_r[i] <= '0;
            end
        end else if (do_write) begin
            for (int i = 0; i < REG_COUNT - 1; i++) begin
                if (idx == REG_IDX_W'(i)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_req.wstrb[b]) begin
                            regs_r[i][8*b +: 8] <= i_req.wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

/* logic/regq_pkg.sv */
package regq_pkg;

    // Size of the register bank and the width of a word index into it
    localparam int REG_COUNT = 16;
    localparam int REG_IDX_W = 4;

    // Register 15 always reads back this value
    localparam logic [31:0] ID_WORD = 32'h5245_4751;

    // AXI response codes used by this slave
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // Request record carried from the capture stage to the execute stage.
    // The word address keeps bits above the index so that out-of-range
    // accesses can still be recognised
    typedef struct packed {
        logic        is_write;
        logic [7:0]  waddr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } req_t;

    // Response record carried from the execute stage to the issue stage
    typedef struct packed {
        logic        is_read;
        logic [31:0] rdata;
        axi_resp_t   resp;
    } rsp_t;

endpackage

/* logic/regq_top.sv */
`timescale 1ns/10ps

module regq_top #(
    parameter int QUEUE_ABITS = 2
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    // Write address channel
    input  logic        i_awvalid,
    output logic        o_awready,
    input  logic [31:0] i_awaddr,
    // Write data channel
    input  logic        i_wvalid,
    output logic        o_wready,
    input  logic [31:0] i_wdata,
    input  logic [3:0]  i_wstrb,
    // Write response channel
    output logic        o_bvalid,
    input  logic        i_bready,
    output logic [1:0]  o_bresp,
    // Read address channel
    input  logic        i_arvalid,
    output logic        o_arready,
    input  logic [31:0] i_araddr,
    // Read data channel
    output logic        o_rvalid,
    input  logic        i_rready,
    output logic [31:0] o_rdata,
    output logic [1:0]  o_rresp
);

    import regq_pkg::*;

    // Capture stage to request queue
    logic req_we;
    req_t req_wdata;
    logic req_full;

    // Request queue to execute stage
    logic req_re;
    req_t req_rdata;
    logic req_nempty;

    // Execute stage to response queue
    logic rsp_we;
    rsp_t rsp_wdata;
    logic rsp_full;

    // Response queue to issue stage
    logic rsp_re;
    rsp_t rsp_rdata;
    logic rsp_nempty;

    axil_req_capture u_capture (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .i_q_full  (req_full),
        .o_q_we    (req_we),
        .o_q_req   (req_wdata)
    );

    req_queue #(
        .QUEUE_ABITS (QUEUE_ABITS),
        .payload_t   (req_t)
    ) u_req_q (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_re     (req_re),
        .i_we     (req_we),
        .i_wdata  (req_wdata),
        .o_rdata  (req_rdata),
        .o_full   (req_full),
        .o_nempty (req_nempty)
    );

    reg_exec u_exec (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_nempty (req_nempty),
        .i_req        (req_rdata),
        .o_req_re     (req_re),
        .i_rsp_full   (rsp_full),
        .o_rsp_we     (rsp_we),
        .o_rsp        (rsp_wdata)
    );

    req_queue #(
        .QUEUE_ABITS (QUEUE_ABITS),
        .payload_t   (rsp_t)
    ) u_rsp_q (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_re     (rsp_re),
        .i_we     (rsp_we),
        .i_wdata  (rsp_wdata),
        .o_rdata  (rsp_rdata),
        .o_full   (rsp_full),
        .o_nempty (rsp_nempty)
    );

    axil_resp_issue u_issue (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_q_nempty (rsp_nempty),
        .i_q_rsp    (rsp_rdata),
        .o_q_re     (rsp_re),
        .o_bvalid   (o_bvalid),
        .i_bready   (i_bready),
        .o_bresp    (o_bresp),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .o_rdata    (o_rdata),
        .o_rresp    (o_rresp)
    );

endmodule

/* logic/req_queue.sv */
`timescale 1ns/10ps

module req_queue #(
    parameter int QUEUE_ABITS = 2,
    parameter type payload_t = logic [31:0]
) (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_re,
    input  logic     i_we,
    input  payload_t i_wdata,
    output payload_t o_rdata,
    output logic     o_full,
    output logic     o_nempty
);

    localparam int DEPTH = 2 ** QUEUE_ABITS;

    // Number of stored entries, one bit wider than the index
    logic [QUEUE_ABITS:0] count_r;
    logic [QUEUE_ABITS:0] count_nxt;

    // Entry zero is always the head of the queue
    payload_t mem_r   [DEPTH];
    payload_t mem_nxt [DEPTH];

    logic is_empty;
    logic is_full;

    assign is_empty = (count_r == '0);
    assign is_full  = (count_r == (QUEUE_ABITS + 1)'(DEPTH));

    always_comb begin
        count_nxt = count_r;
        for (int i = 0; i < DEPTH; i++) begin
            mem_nxt[i] = mem_r[i];
        end

        if (i_re && i_we) begin
            for (int i = 1; i < DEPTH; i++) begin
                mem_nxt[i - 1] = mem_r[i];
            end
            // With an empty queue the new entry leaves through the bypass
            if (!is_empty) begin
                mem_nxt[int'(count_r) - 1] = i_wdata;
            end
        end else if (i_we) begin
            if (!is_full) begin
                count_nxt = count_r + 1'b1;
                mem_nxt[int'(count_r)] = i_wdata;
            end
        end else if (i_re) begin
            if (!is_empty) begin
                count_nxt = count_r - 1'b1;
            end
            for (int i = 1; i < DEPTH; i++) begin
                mem_nxt[i - 1] = mem_r[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            count_r <= '0;
        end else begin
            count_r <= count_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_r[i] <= mem_nxt[i];
        end
    end

    // Early full leaves one slot for a push already in flight
    assign o_full   = (count_r >= (QUEUE_ABITS + 1)'(DEPTH - 1));
    assign o_nempty = i_we | ~is_empty;
    assign o_rdata  = is_empty ? i_wdata : mem_r[0];

endmodule

/* project.f */
logic/regq_pkg.sv
logic/req_queue.sv
logic/axil_req_capture.sv
logic/reg_exec.sv
logic/axil_resp_issue.sv
logic/regq_top.sv
bench/tb_regq.sv
